//--- verilog/ethRxCfgPkg.sv
// Receive configuration constants
package ethRxCfgPkg;

////////////////////////////////////////////////////////////////////////////
// Frame limits

        // Destination address through FCS
        localparam int MaxFrameBytes = 1518;
        // FCS length, fewer bytes means no CRC to check
        localparam int FcsBytes = 4;
        // Idle MRxClk cycles needed ahead of a new SFD
        localparam int IfgNibbles = 24;
        localparam int IfgCntWidth = $clog2(IfgNibbles + 1);

////////////////////////////////////////////////////////////////////////////
// Buffer and CRC

        // Power of two, pointers wrap naturally
        localparam int FifoDepth = 16;
        localparam int FifoAddrWidth = $clog2(FifoDepth);
        // Reflected polynomial, bits go LSB first on the wire
        localparam logic [31:0] CrcPoly = 32'hEDB8_8320;
        localparam logic [31:0] CrcInit = 32'hFFFF_FFFF;
        // Register value after a frame with a correct FCS
        localparam logic [31:0] CrcResidue = 32'hDEBB_20E3;

endpackage

//--- verilog/ethRxTypesPkg.sv
// Receive datapath types
package ethRxTypesPkg;

        // Bytes in a frame, wide enough for MaxFrameBytes
        typedef logic [10:0] byteCnt_t;

        // Buffer entry
        // Either one data byte or an end marker without data
        typedef struct packed {
                logic [7:0] data;
                logic       sof;
                logic       eof;
                logic       abort;
        } rxEntry_t;

        // One status word per received frame
        typedef struct packed {
                byteCnt_t byteCount;
                logic     crcOk;
                logic     tooLong;
                logic     runt;
        } rxStatus_t;

        // One hot receive state
        typedef struct packed {
                logic idle;
                logic preamble;
                logic sfd;
                logic data0;
                logic data1;
                logic drop;
        } rxState_t;

endpackage

//--- verilog/ethRxStateM.sv
// Receive state machine
`timescale 1ns/10ps

module ethRxStateM
(
        input  logic                    MRxClk,
        input  logic                    Reset,
        input  logic                    MRxDV,
        input  logic                    mrxdEq5,
        input  logic                    mrxdEqD,
        input  logic                    Transmitting,
        input  logic                    ifgDone,
        input  logic                    byteCntMax,
        output ethRxTypesPkg::rxState_t state
);

        logic startIdle;
        logic startPreamble;
        logic startSfd;
        logic startData0;
        logic startData1;
        logic startDrop;

////////////////////////////////////////////////////////////////////////////
// Start conditions

        // Carrier gone, any busy state returns to idle
        assign startIdle = ~MRxDV & (state.drop | state.preamble | state.sfd |
                state.data0 | state.data1);

        // Activity other than 5 opens the preamble
        assign startPreamble = MRxDV & ~mrxdEq5 & state.idle & ~Transmitting;

        // A 5 nibble may be the last before the SFD
        assign startSfd = MRxDV & mrxdEq5 & (state.idle & ~Transmitting | state.preamble);

        // SFD accepted only after a full gap
        assign startData0 = MRxDV & (state.sfd & mrxdEqD & ifgDone | state.data1);

        // High nibble of the byte, unless the frame is full
        assign startData1 = MRxDV & state.data0 & ~byteCntMax;

        // Own transmission, short gap or frame too long
        assign startDrop = MRxDV & (state.idle & Transmitting |
                state.sfd & mrxdEqD & ~ifgDone | state.data0 & byteCntMax);

////////////////////////////////////////////////////////////////////////////
// State flags

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        // Wait for the line to go quiet first
                        state <= '{drop: 1'b1, default: 1'b0};
                end
                else
                begin
                        if (startPreamble | startSfd | startDrop)
                                state.idle <= 1'b0;
                        else if (startIdle)
                                state.idle <= 1'b1;

                        if (startSfd | startIdle | startDrop)
                                state.preamble <= 1'b0;
                        else if (startPreamble)
                                state.preamble <= 1'b1;

                        // Stays in sfd on repeated 5 nibbles
                        if (startPreamble | startIdle | startData0 | startDrop)
                                state.sfd <= 1'b0;
                        else if (startSfd)
                                state.sfd <= 1'b1;

                        // data0 and data1 alternate per nibble
                        if (startIdle | startData1 | startDrop)
                                state.data0 <= 1'b0;
                        else if (startData0)
                                state.data0 <= 1'b1;

                        if (startIdle | startData0 | startDrop)
                                state.data1 <= 1'b0;
                        else if (startData1)
                                state.data1 <= 1'b1;

                        // Drop ends only with the carrier
                        if (startIdle)
                                state.drop <= 1'b0;
                        else if (startDrop)
                                state.drop <= 1'b1;
                end
        end

endmodule

//--- verilog/ethRxCounters.sv
// Receive byte and gap counters
`timescale 1ns/10ps

module ethRxCounters
(
        input  logic                    MRxClk,
        input  logic                    Reset,
        input  logic                    MRxDV,
        input  ethRxTypesPkg::rxState_t state,
        output logic                    byteCntMax,
        output logic                    ifgDone,
        output ethRxTypesPkg::byteCnt_t byteCnt
);
        import ethRxCfgPkg::*;
        import ethRxTypesPkg::*;

        logic [IfgCntWidth-1:0] ifgCnt;

        // Inter-frame gap
        // Counts idle cycles up to the limit
        // Held through preamble and SFD, cleared once a frame is carried
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        ifgCnt <= '0;
                else if (~MRxDV)
                begin
                        if (!ifgDone)
                                ifgCnt <= ifgCnt + 1'b1;
                end
                else if (state.data0 | state.data1 | state.drop)
                        ifgCnt <= '0;
        end

        assign ifgDone = (ifgCnt == IfgCntWidth'(IfgNibbles));

        // Bytes of the current frame, one per completed data1
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        byteCnt <= '0;
                else if (state.sfd)
                        byteCnt <= '0;
                else if (state.data1 & MRxDV)
                        byteCnt <= byteCnt + 1'b1;
        end

        // Frame full, one more byte would pass the limit
        assign byteCntMax = (byteCnt == byteCnt_t'(MaxFrameBytes));

endmodule

//--- verilog/ethRxFront.sv
// Receive nibble front end
`timescale 1ns/10ps

module ethRxFront
(
        input  logic                    MRxClk,
        input  logic                    Reset,
        input  logic                    MRxDV,
        input  logic [3:0]              MRxD,
        input  logic                    Transmitting,
        output logic                    fifoWr,
        output ethRxTypesPkg::rxEntry_t fifoWrData
);
        import ethRxTypesPkg::*;

        rxState_t   state;
        byteCnt_t   byteCnt;
        logic       mrxdEq5;
        logic       mrxdEqD;
        logic       ifgDone;
        logic       byteCntMax;
        logic [3:0] lowNibble;
        logic       byteDone;
        logic       frameEnd;
        logic       frameCut;

        // Preamble and SFD nibbles
        assign mrxdEq5 = (MRxD == 4'h5);
        assign mrxdEqD = (MRxD == 4'hD);

        ethRxStateM stateM
        (
                .MRxClk       (MRxClk),
                .Reset        (Reset),
                .MRxDV        (MRxDV),
                .mrxdEq5      (mrxdEq5),
                .mrxdEqD      (mrxdEqD),
                .Transmitting (Transmitting),
                .ifgDone      (ifgDone),
                .byteCntMax   (byteCntMax),
                .state        (state)
        );

        ethRxCounters counters
        (
                .MRxClk     (MRxClk),
                .Reset      (Reset),
                .MRxDV      (MRxDV),
                .state      (state),
                .byteCntMax (byteCntMax),
                .ifgDone    (ifgDone),
                .byteCnt    (byteCnt)
        );

////////////////////////////////////////////////////////////////////////////
// Byte assembly

        // High nibble present, byte complete
        assign byteDone = state.data1 & MRxDV;
        // Carrier fell inside the frame
        assign frameEnd = ~MRxDV & (state.data0 | state.data1);
        // Same cycle the state machine leaves data0 for drop
        assign frameCut = MRxDV & state.data0 & byteCntMax;

        // Low nibble comes first on the MII
        always_ff @(posedge MRxClk)
        begin
                if (state.data0 & MRxDV)
                        lowNibble <= MRxD;
        end

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        fifoWr <= 1'b0;
                else
                        fifoWr <= byteDone | frameEnd | frameCut;
        end

        // Data byte, or end marker with abort on a cut frame
        always_ff @(posedge MRxClk)
        begin
                if (byteDone)
                        fifoWrData <= '{data: {MRxD, lowNibble}, sof: (byteCnt == '0),
                                eof: 1'b0, abort: 1'b0};
                else if (frameEnd | frameCut)
                        fifoWrData <= '{data: 8'h00, sof: 1'b0, eof: 1'b1, abort: frameCut};
        end

endmodule

//--- verilog/ethRxFifo.sv
// Receive entry FIFO
`timescale 1ns/10ps

module ethRxFifo
(
        input  logic                    MRxClk,
        input  logic                    Reset,
        input  logic                    fifoWr,
        input  ethRxTypesPkg::rxEntry_t fifoWrData,
        input  logic                    fifoRd,
        output ethRxTypesPkg::rxEntry_t fifoRdData,
        output logic                    fifoEmpty,
        output logic                    fifoFull
);
        import ethRxCfgPkg::*;
        import ethRxTypesPkg::*;

        rxEntry_t mem [0:FifoDepth-1];
        // One extra bit tells full from empty
        logic [FifoAddrWidth:0] wrPtr;
        logic [FifoAddrWidth:0] rdPtr;
        logic wrEn;
        logic rdEn;

        // Write into a full buffer is lost
        assign wrEn = fifoWr & ~fifoFull;
        assign rdEn = fifoRd & ~fifoEmpty;

        assign fifoEmpty = (wrPtr == rdPtr);
        assign fifoFull = (wrPtr[FifoAddrWidth] != rdPtr[FifoAddrWidth]) &&
                (wrPtr[FifoAddrWidth-1:0] == rdPtr[FifoAddrWidth-1:0]);

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        wrPtr <= '0;
                        rdPtr <= '0;
                end
                else
                begin
                        if (wrEn)
                                wrPtr <= wrPtr + 1'b1;
                        if (rdEn)
                                rdPtr <= rdPtr + 1'b1;
                end
        end

        // Storage
        always_ff @(posedge MRxClk)
        begin
                if (wrEn)
                        mem[wrPtr[FifoAddrWidth-1:0]] <= fifoWrData;
        end

        // Registered read port, data one cycle after fifoRd
        always_ff @(posedge MRxClk)
        begin
                if (rdEn)
                        fifoRdData <= mem[rdPtr[FifoAddrWidth-1:0]];
        end

endmodule

//--- verilog/ethRxCrcCheck.sv
// Receive CRC check and status
`timescale 1ns/10ps

module ethRxCrcCheck
(
        input  logic                     MRxClk,
        input  logic                     Reset,
        input  logic                     fifoEmpty,
        input  ethRxTypesPkg::rxEntry_t  fifoRdData,
        output logic                     fifoRd,
        output ethRxTypesPkg::rxEntry_t  rxOut,
        output logic                     rxOutValid,
        output ethRxTypesPkg::rxStatus_t rxStat,
        output logic                     rxStatValid
);
        import ethRxCfgPkg::*;
        import ethRxTypesPkg::*;

        logic        rdValid;
        logic        isByte;
        logic        isEnd;
        logic        runt;
        logic [31:0] crc;
        logic [31:0] crcNext;
        byteCnt_t    frameCnt;

        // One byte through the reflected CRC-32
        function automatic logic [31:0] crcByte(input logic [31:0] crcIn, input logic [7:0] d);
                logic [31:0] c;
                c = crcIn ^ {24'h000000, d};
                for (int i = 0; i < 8; i++)
                        c = c[0] ? ((c >> 1) ^ CrcPoly) : (c >> 1);
                return c;
        endfunction

////////////////////////////////////////////////////////////////////////////
// FIFO drain

        // Drain at full rate, bytes come at most every second cycle
        assign fifoRd = ~fifoEmpty;

        // Read data valid one cycle after the read
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        rdValid <= 1'b0;
                else
                        rdValid <= fifoRd;
        end

        assign isByte = rdValid & ~fifoRdData.eof;
        assign isEnd = rdValid & fifoRdData.eof;

////////////////////////////////////////////////////////////////////////////
// CRC and byte count

        // Seed on the first byte of each frame
        assign crcNext = crcByte(fifoRdData.sof ? CrcInit : crc, fifoRdData.data);

        always_ff @(posedge MRxClk)
        begin
                if (isByte)
                        crc <= crcNext;
        end

        // Zero between frames so an empty frame reports zero
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        frameCnt <= '0;
                else if (isEnd)
                        frameCnt <= '0;
                else if (isByte)
                        frameCnt <= fifoRdData.sof ? byteCnt_t'(1) : frameCnt + 1'b1;
        end

        // Too short to hold an FCS
        assign runt = (frameCnt < byteCnt_t'(FcsBytes));

////////////////////////////////////////////////////////////////////////////
// Outputs

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        rxOutValid <= 1'b0;
                        rxStatValid <= 1'b0;
                end
                else
                begin
                        rxOutValid <= isByte;
                        rxStatValid <= isEnd;
                end
        end

        always_ff @(posedge MRxClk)
        begin
                // Byte forwarded with its sof flag
                if (isByte)
                        rxOut <= fifoRdData;
                // Status from the end marker
                if (isEnd)
                        rxStat <= '{byteCount: frameCnt,
                                crcOk: (crc == CrcResidue) & ~fifoRdData.abort & ~runt,
                                tooLong: fifoRdData.abort, runt: runt};
        end

endmodule

//--- verilog/ethRx.sv
// Ethernet receive front top
`timescale 1ns/10ps

module ethRx
(
        input  logic                     MRxClk,
        input  logic                     Reset,
        input  logic                     MRxDV,
        input  logic [3:0]               MRxD,
        input  logic                     Transmitting,
        output ethRxTypesPkg::rxEntry_t  rxOut,
        output logic                     rxOutValid,
        output ethRxTypesPkg::rxStatus_t rxStat,
        output logic                     rxStatValid
);
        import ethRxTypesPkg::*;

        // Producer to buffer
        logic     fifoWr;
        rxEntry_t fifoWrData;
        // Buffer to consumer
        logic     fifoRd;
        rxEntry_t fifoRdData;
        logic     fifoEmpty;
        logic     fifoFull;

        ethRxFront front
        (
                .MRxClk       (MRxClk),
                .Reset        (Reset),
                .MRxDV        (MRxDV),
                .MRxD         (MRxD),
                .Transmitting (Transmitting),
                .fifoWr       (fifoWr),
                .fifoWrData   (fifoWrData)
        );

        ethRxFifo fifo
        (
                .MRxClk     (MRxClk),
                .Reset      (Reset),
                .fifoWr     (fifoWr),
                .fifoWrData (fifoWrData),
                .fifoRd     (fifoRd),
                .fifoRdData (fifoRdData),
                .fifoEmpty  (fifoEmpty),
                .fifoFull   (fifoFull)
        );

        ethRxCrcCheck crcCheck
        (
                .MRxClk      (MRxClk),
                .Reset       (Reset),
                .fifoEmpty   (fifoEmpty),
                .fifoRdData  (fifoRdData),
                .fifoRd      (fifoRd),
                .rxOut       (rxOut),
                .rxOutValid  (rxOutValid),
                .rxStat      (rxStat),
                .rxStatValid (rxStatValid)
        );

endmodule

//--- bench/ethRxTb_props.sv
// Receive state machine checks
`timescale 1ns/10ps

module ethRxTbProps
(
        input logic                    MRxClk,
        input logic                    Reset,
        input logic                    MRxDV,
        input ethRxTypesPkg::rxState_t state,
        input logic                    fifoWr,
        input logic                    fifoFull
);

////////////////////////////////////////////////////////////////////////////
// State machine

        // One hot flags
        onlyOneState: assert property (@(posedge MRxClk) disable iff (Reset)
                $onehot0(state))
                else $error("More than one receive state flag is set");

        // Carrier loss ends any frame or drop
        carrierFallIdle: assert property (@(posedge MRxClk) disable iff (Reset)
                $fell(MRxDV) |=> state.idle)
                else $error("Receive state not idle one cycle after MRxDV fell");

////////////////////////////////////////////////////////////////////////////
// Buffer

        // Drain is faster than fill, so a full buffer is a design error
        noOverflow: assert property (@(posedge MRxClk) disable iff (Reset)
                fifoWr |-> !fifoFull)
                else $error("FIFO written while full");

endmodule

//--- bench/ethRxTb.sv
// Receive front testbench
`timescale 1ns/10ps

module ethRxTb;
        import ethRxCfgPkg::*;
        import ethRxTypesPkg::*;

        localparam int ClkPeriod = 100;
        localparam int ResetCycles = 4;
        // Bound on the wait for the last outputs
        localparam int DrainCycles = 200;
        // Quiet cycles in which a stray output would still show up
        localparam int SettleCycles = 40;

        logic      MRxClk;
        logic      Reset;
        logic      MRxDV;
        logic [3:0] MRxD;
        logic      Transmitting;
        rxEntry_t  rxOut;
        logic      rxOutValid;
        rxStatus_t rxStat;
        logic      rxStatValid;

        // Frames from the data file
        // Payload bytes of all frames in one flat queue
        string      frameName[$];
        int         frameTx[$];
        int         frameGap[$];
        int         framePre[$];
        int         frameStart[$];
        int         frameLen[$];
        string      frameExpect[$];
        rxStatus_t  frameStat[$];
        logic [7:0] payload[$];

        // Outputs still to come in arrival order
        rxEntry_t   expByteQ[$];
        string      expByteName[$];
        rxStatus_t  expStatQ[$];
        string      expStatName[$];

        longint watchdogTime = 0;

        ethRx u_dut
        (
                .MRxClk       (MRxClk),
                .Reset        (Reset),
                .MRxDV        (MRxDV),
                .MRxD         (MRxD),
                .Transmitting (Transmitting),
                .rxOut        (rxOut),
                .rxOutValid   (rxOutValid),
                .rxStat       (rxStat),
                .rxStatValid  (rxStatValid)
        );

        // State machine and FIFO checks inside the DUT
        // State flags come from the front end
        bind ethRx ethRxTbProps props
        (
                .MRxClk   (MRxClk),
                .Reset    (Reset),
                .MRxDV    (MRxDV),
                .state    (front.state),
                .fifoWr   (fifoWr),
                .fifoFull (fifoFull)
        );

        initial MRxClk = 1'b0;
        always #(ClkPeriod / 2) MRxClk = ~MRxClk;

////////////////////////////////////////////////////////////////////////////
// Reporting and compares

        task automatic stopWithFailure(input string reason);
                $display("%s", reason);
                $display("STATUS: FAIL");
                $fatal(1);
        endtask

        task automatic checkByte(input string testName, input rxEntry_t expected,
                input rxEntry_t actual);
                string msg;
                if (actual !== expected)
                begin
                        msg = $sformatf("Fail %s byte: expected data %h sof %b", testName,
                                expected.data, expected.sof);
                        msg = {msg, $sformatf(", got data %h sof %b eof %b abort %b",
                                actual.data, actual.sof, actual.eof, actual.abort)};
                        stopWithFailure(msg);
                end
        endtask

        task automatic checkStatus(input string testName, input rxStatus_t expected,
                input rxStatus_t actual);
                string msg;
                if (actual !== expected)
                begin
                        msg = $sformatf("Fail %s status: expected count %0d ok %b long %b runt %b",
                                testName, expected.byteCount, expected.crcOk, expected.tooLong,
                                expected.runt);
                        msg = {msg, $sformatf(", got count %0d ok %b long %b runt %b",
                                actual.byteCount, actual.crcOk, actual.tooLong, actual.runt)};
                        stopWithFailure(msg);
                end
        endtask

////////////////////////////////////////////////////////////////////////////
// Test data

        task automatic readTestData();
                int        fd;
                int        c;
                int        n;
                int        i;
                int        v;
                int        tx;
                int        gap;
                int        pre;
                int        cnt;
                int        statCnt;
                int        ok;
                int        tl;
                int        rt;
                string     name;
                string     kind;
                string     expectKind;
                rxStatus_t st;
                fd = $fopen("bench/ethRx_testdata.txt", "r");
                if (fd == 0)
                        stopWithFailure("Cannot open the test data file");
                while ($fscanf(fd, "%s", name) == 1)
                begin
                        if (name[0] == "#")
                        begin
                                // Rest of a comment line
                                c = $fgetc(fd);
                                while (c != "\n" && c != -1)
                                        c = $fgetc(fd);
                        end
                        else
                        begin
                                n = $fscanf(fd, "%d %d %d %s %d", tx, gap, pre, kind, cnt);
                                if (n != 5)
                                        stopWithFailure({"Malformed record for test ", name});
                                frameStart.push_back(payload.size());
                                for (i = 0; i < cnt; i++)
                                begin
                                        if (kind == "hex")
                                                n = $fscanf(fd, "%h", v);
                                        else
                                                v = $urandom;
                                        payload.push_back(v[7:0]);
                                end
                                n = $fscanf(fd, "%s", expectKind);
                                st = '0;
                                if (expectKind == "stat")
                                begin
                                        n = $fscanf(fd, "%d %d %d %d", statCnt, ok, tl, rt);
                                        st = '{byteCount: byteCnt_t'(statCnt), crcOk: ok[0],
                                                tooLong: tl[0], runt: rt[0]};
                                end
                                // A cut frame ends at the limit and never has a good CRC
                                else if (expectKind == "cut")
                                        st = '{byteCount: byteCnt_t'(MaxFrameBytes), crcOk: 1'b0,
                                                tooLong: 1'b1, runt: 1'b0};
                                frameName.push_back(name);
                                frameTx.push_back(tx);
                                frameGap.push_back(gap);
                                framePre.push_back(pre);
                                frameLen.push_back(cnt);
                                frameExpect.push_back(expectKind);
                                frameStat.push_back(st);
                        end
                end
                $fclose(fd);
        endtask

////////////////////////////////////////////////////////////////////////////
// MII stimulus

        task automatic driveNibble(input logic [3:0] d);
                @(posedge MRxClk);
                MRxDV <= 1'b1;
                MRxD <= d;
        endtask

        // Expected bytes and status of one frame
        task automatic queueExpected(input int f);
                int       i;
                int       nBytes;
                rxEntry_t e;
                if (frameExpect[f] != "none")
                begin
                        nBytes = (frameExpect[f] == "cut") ? MaxFrameBytes : frameLen[f];
                        for (i = 0; i < nBytes; i++)
                        begin
                                e = '{data: payload[frameStart[f] + i], sof: (i == 0),
                                        eof: 1'b0, abort: 1'b0};
                                expByteQ.push_back(e);
                                expByteName.push_back(frameName[f]);
                        end
                        expStatQ.push_back(frameStat[f]);
                        expStatName.push_back(frameName[f]);
                end
        endtask

        task automatic sendFrame(input int f);
                int         i;
                logic [7:0] b;
                // Carrier low for the gap while Transmitting is set for the frame
                for (i = 0; i < frameGap[f]; i++)
                begin
                        @(posedge MRxClk);
                        MRxDV <= 1'b0;
                        MRxD <= 4'h0;
                        Transmitting <= (frameTx[f] != 0);
                end
                queueExpected(f);
                for (i = 0; i < framePre[f]; i++)
                        driveNibble(4'h5);
                driveNibble(4'hD);
                // Low nibble first
                for (i = 0; i < frameLen[f]; i++)
                begin
                        b = payload[frameStart[f] + i];
                        driveNibble(b[3:0]);
                        driveNibble(b[7:4]);
                end
        endtask

////////////////////////////////////////////////////////////////////////////
// Output monitor on the falling edge

        always @(negedge MRxClk)
        begin
                if (rxOutValid === 1'b1)
                begin
                        if (expByteQ.size() == 0)
                                stopWithFailure("A byte came out while no frame was expected");
                        else
                                checkByte(expByteName.pop_front(), expByteQ.pop_front(), rxOut);
                end
                if (rxStatValid === 1'b1)
                begin
                        if (expStatQ.size() == 0)
                                stopWithFailure("A status word came out while none was expected");
                        else
                                checkStatus(expStatName.pop_front(), expStatQ.pop_front(), rxStat);
                end
        end

        // Watchdog armed once the frames are known
        initial
        begin
                wait (watchdogTime > 0);
                #(watchdogTime);
                stopWithFailure("Watchdog expired before the run finished");
        end

        initial
        begin
                int     f;
                int     i;
                longint budget;
                void'($urandom(32'h85e0_397e));
                Reset = 1'b1;
                MRxDV = 1'b0;
                MRxD = 4'h0;
                Transmitting = 1'b0;
                readTestData();
                // Nibbles plus gaps plus margin for reset and drain
                budget = ResetCycles + DrainCycles + SettleCycles;
                for (f = 0; f < frameName.size(); f++)
                        budget += frameGap[f] + framePre[f] + 1 + 2 * frameLen[f];
                watchdogTime = budget * 2 * ClkPeriod;
                repeat (ResetCycles) @(posedge MRxClk);
                Reset <= 1'b0;
                for (f = 0; f < frameName.size(); f++)
                        sendFrame(f);
                @(posedge MRxClk);
                MRxDV <= 1'b0;
                MRxD <= 4'h0;
                Transmitting <= 1'b0;
                for (i = 0; i < DrainCycles && (expByteQ.size() + expStatQ.size()) != 0; i++)
                        @(posedge MRxClk);
                repeat (SettleCycles) @(posedge MRxClk);
                if (expByteQ.size() == 0 && expStatQ.size() == 0)
                begin
                        $display("STATUS: PASS");
                        $finish;
                end
                else
                        stopWithFailure($sformatf("Missing at the end: %0d bytes, %0d status words",
                                expByteQ.size(), expStatQ.size()));
        end

endmodule

//--- bench/ethRx_testdata.txt
# name tx gap preamble kind count [bytes] expect [byteCount crcOk tooLong runt]
# kind hex lists the bytes, rand draws them; expect is stat, cut or none
goodDigits 0 30 15 hex 13 31 32 33 34 35 36 37 38 39 26 39 F4 CB stat 13 1 0 0
goodOne 0 30 7 hex 5 61 43 BE B7 E8 stat 5 1 0 0
goodZero 0 24 15 hex 4 00 00 00 00 stat 4 1 0 0
goodAbc 0 30 15 hex 7 61 62 63 C2 41 24 35 stat 7 1 0 0
badFcs 0 30 15 hex 13 31 32 33 34 35 36 37 38 39 26 39 F4 CA stat 13 0 0 0
txBusy 1 30 15 hex 7 61 62 63 C2 41 24 35 none
shortGap 0 23 15 hex 5 61 43 BE B7 E8 none
afterGap 0 30 15 hex 13 31 32 33 34 35 36 37 38 39 26 39 F4 CB stat 13 1 0 0
runtPair 0 30 15 hex 2 01 02 stat 2 0 0 1
tooLong 0 30 15 rand 1530 cut
goodAfterCut 0 30 15 hex 5 61 43 BE B7 E8 stat 5 1 0 0

//--- ethRx.f
verilog/ethRxCfgPkg.sv
verilog/ethRxTypesPkg.sv
verilog/ethRxStateM.sv
verilog/ethRxCounters.sv
verilog/ethRxFront.sv
verilog/ethRxFifo.sv
verilog/ethRxCrcCheck.sv
verilog/ethRx.sv
bench/ethRxTb_props.sv
bench/ethRxTb.sv

//--- Bender.yml
package:
  name: ethRx

sources:
  - verilog/ethRxCfgPkg.sv
  - verilog/ethRxTypesPkg.sv
  - verilog/ethRxStateM.sv
  - verilog/ethRxCounters.sv
  - verilog/ethRxFront.sv
  - verilog/ethRxFifo.sv
  - verilog/ethRxCrcCheck.sv
  - verilog/ethRx.sv
  - target: test
    files:
      - bench/ethRxTb_props.sv
      - bench/ethRxTb.sv
